//--- logic/game_pkg.sv
package game_pkg;

   typedef logic [4:0] tile_t;

   typedef enum logic [2:0] {
      idle,
      left,
      right,
      up,
      down
   } direction_t;

   typedef enum logic [1:0] {
      scatter,
      chase,
      frightened,
      eaten
   } ghost_mode_t;

   typedef logic [7:0] level_t;
   typedef logic [1:0] lives_t;
   typedef logic [31:0] score_t;
   typedef logic [31:0] ticks_t;
   typedef logic [2:0] slot_t;

   localparam int level_slots = 5;

   // seconds per tuned level, first entry is level 1
   localparam logic [5:0] scatter_seconds [level_slots] = '{10, 9, 8, 6, 4};
   localparam logic [5:0] chase_seconds [level_slots] = '{15, 20, 25, 30, 35};
   localparam logic [5:0] frightened_seconds [level_slots] = '{7, 6, 5, 4, 2};
   localparam logic [5:0] pinky_leave_seconds [level_slots] = '{15, 13, 11, 9, 5};
   localparam logic [5:0] inky_leave_seconds [level_slots] = '{25, 21, 17, 13, 8};
   localparam logic [5:0] clyde_leave_seconds [level_slots] = '{35, 30, 25, 20, 13};

   localparam int twinkle_seconds = 2;
   localparam int freeze_seconds = 1;
   localparam int max_phases = 8;
   localparam int last_scatter_level = 5;
   localparam lives_t start_lives = 2'd3;
   localparam score_t ghost_points = 200;

   // levels past the table reuse the last slot
   function automatic slot_t level_slot(level_t level);
      if (level == '0 || level > level_t'(level_slots)) begin
         return slot_t'(level_slots - 1);
      end
      return slot_t'(level - 1'b1);
   endfunction

endpackage

//--- logic/mode_timing_if.sv
`timescale 1ns/1ns

interface mode_timing_if;
   import game_pkg::*;

   ticks_t scatter_ticks;
   ticks_t chase_ticks;
   ticks_t frightened_ticks;
   ticks_t pinky_leave_ticks;
   ticks_t inky_leave_ticks;
   ticks_t clyde_leave_ticks;

   modport cfg (
      output scatter_ticks,
      output chase_ticks,
      output frightened_ticks,
      output pinky_leave_ticks,
      output inky_leave_ticks,
      output clyde_leave_ticks
   );

   modport sched (
      input scatter_ticks,
      input chase_ticks,
      input frightened_ticks
   );

   modport house (
      input pinky_leave_ticks,
      input inky_leave_ticks,
      input clyde_leave_ticks
   );

endinterface

//--- logic/level_config.sv
`timescale 1ns/1ns

module level_config #(
   parameter game_pkg::ticks_t ticks_per_second = 25_000_000
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             level_up,
   output game_pkg::level_t level,
   mode_timing_if.cfg       timing
);
   import game_pkg::*;

   slot_t slot;

   function automatic ticks_t to_ticks(logic [5:0] seconds);
      return ticks_t'(seconds) * ticks_per_second;
   endfunction

   assign slot = level_slot(level);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         level <= level_t'(1);
      end else if (level_up) begin
         level <= level + 1'b1;
      end
   end

   // limits follow the level one cycle later
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         timing.scatter_ticks <= to_ticks(scatter_seconds[0]);
         timing.chase_ticks <= to_ticks(chase_seconds[0]);
         timing.frightened_ticks <= to_ticks(frightened_seconds[0]);
         timing.pinky_leave_ticks <= to_ticks(pinky_leave_seconds[0]);
         timing.inky_leave_ticks <= to_ticks(inky_leave_seconds[0]);
         timing.clyde_leave_ticks <= to_ticks(clyde_leave_seconds[0]);
      end else begin
         timing.scatter_ticks <= to_ticks(scatter_seconds[slot]);
         timing.chase_ticks <= to_ticks(chase_seconds[slot]);
         timing.frightened_ticks <= to_ticks(frightened_seconds[slot]);
         timing.pinky_leave_ticks <= to_ticks(pinky_leave_seconds[slot]);
         timing.inky_leave_ticks <= to_ticks(inky_leave_seconds[slot]);
         timing.clyde_leave_ticks <= to_ticks(clyde_leave_seconds[slot]);
      end
   end

endmodule

//--- logic/mode_scheduler.sv
`timescale 1ns/1ns

module mode_scheduler (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  pause,
   input  logic                  round_restart,
   input  logic                  energizer,
   input  game_pkg::level_t      level,
   mode_timing_if.sched          timing,
   output game_pkg::ghost_mode_t global_mode,
   output logic                  twinkle
);
   import game_pkg::*;

   ghost_mode_t prev_mode;
   ticks_t mode_count;
   ticks_t fright_count;
   ticks_t fright_left;
   logic [3:0] phase_count;
   logic [5:0] fright_seconds;
   logic scatter_allowed;

   assign scatter_allowed = (phase_count < max_phases) && (level <= last_scatter_level);

   // remaining * seconds <= total * twinkle seconds, so no divider is needed
   assign fright_left = timing.frightened_ticks - fright_count;
   assign fright_seconds = frightened_seconds[level_slot(level)];
   assign twinkle = (global_mode == frightened) &&
                    (fright_left * fright_seconds <= timing.frightened_ticks * twinkle_seconds);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         global_mode <= scatter;
         prev_mode <= scatter;
         mode_count <= '0;
         fright_count <= '0;
         phase_count <= 4'd1;
      end else if (round_restart) begin
         global_mode <= scatter;
         prev_mode <= scatter;
         mode_count <= '0;
         fright_count <= '0;
         phase_count <= 4'd1;
      end else if (!pause) begin
         case (global_mode)
            frightened: begin
               if (energizer) begin
                  fright_count <= '0;
               end else if (fright_count == timing.frightened_ticks - 1) begin
                  global_mode <= prev_mode;
                  fright_count <= '0;
               end else begin
                  fright_count <= fright_count + 1;
               end
            end
            scatter: begin
               if (energizer) begin
                  prev_mode <= scatter;
                  global_mode <= frightened;
                  fright_count <= '0;
               end else if (mode_count == timing.scatter_ticks - 1 ||
                            level > last_scatter_level) begin
                  global_mode <= chase;
                  mode_count <= '0;
                  phase_count <= phase_count + 1'b1;
               end else begin
                  mode_count <= mode_count + 1;
               end
            end
            chase: begin
               if (energizer) begin
                  prev_mode <= chase;
                  global_mode <= frightened;
                  fright_count <= '0;
               end else if (mode_count == timing.chase_ticks - 1) begin
                  mode_count <= '0;
                  // stays in chase once scatter is used up
                  if (scatter_allowed) begin
                     global_mode <= scatter;
                     phase_count <= phase_count + 1'b1;
                  end
               end else begin
                  mode_count <= mode_count + 1;
               end
            end
            default: begin
               global_mode <= scatter;
            end
         endcase
      end
   end

endmodule

//--- logic/collision_judge.sv
`timescale 1ns/1ns

module collision_judge (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  round_active,
   input  game_pkg::tile_t       pacman_x,
   input  game_pkg::tile_t       pacman_y,
   input  game_pkg::tile_t       blinky_x,
   input  game_pkg::tile_t       blinky_y,
   input  game_pkg::tile_t       pinky_x,
   input  game_pkg::tile_t       pinky_y,
   input  game_pkg::tile_t       inky_x,
   input  game_pkg::tile_t       inky_y,
   input  game_pkg::tile_t       clyde_x,
   input  game_pkg::tile_t       clyde_y,
   input  game_pkg::ghost_mode_t blinky_mode,
   input  game_pkg::ghost_mode_t pinky_mode,
   input  game_pkg::ghost_mode_t inky_mode,
   input  game_pkg::ghost_mode_t clyde_mode,
   output game_pkg::lives_t      lives,
   output game_pkg::score_t      score,
   output logic                  life_lost,
   output logic                  out_of_lives
);
   import game_pkg::*;

   tile_t ghost_x [4];
   tile_t ghost_y [4];
   ghost_mode_t ghost_mode [4];
   logic lethal;
   logic hit;
   logic [2:0] caught_count;

   assign ghost_x = '{blinky_x, pinky_x, inky_x, clyde_x};
   assign ghost_y = '{blinky_y, pinky_y, inky_y, clyde_y};
   assign ghost_mode = '{blinky_mode, pinky_mode, inky_mode, clyde_mode};

   always_comb begin
      lethal = 1'b0;
      caught_count = '0;
      for (int i = 0; i < 4; i++) begin
         if (ghost_x[i] == pacman_x && ghost_y[i] == pacman_y) begin
            if (ghost_mode[i] == scatter || ghost_mode[i] == chase) begin
               lethal = 1'b1;
            end else if (ghost_mode[i] == frightened) begin
               caught_count = caught_count + 1'b1;
            end
         end
      end
   end

   // one life per contact, the freeze follows the pulse
   assign hit = round_active && lethal && !life_lost && (lives != '0);
   assign out_of_lives = (lives == '0);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         lives <= start_lives;
         score <= '0;
         life_lost <= 1'b0;
      end else begin
         life_lost <= hit;
         if (hit) begin
            lives <= lives - 1'b1;
         end
         if (round_active) begin
            score <= score + ghost_points * score_t'(caught_count);
         end
      end
   end

endmodule

//--- logic/round_sequencer.sv
`timescale 1ns/1ns

module round_sequencer #(
   parameter game_pkg::ticks_t ticks_per_second = 25_000_000
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 ready,
   input  logic                 all_dots_eaten,
   input  logic                 life_lost,
   input  logic                 out_of_lives,
   input  logic                 restart_ack,
   input  game_pkg::direction_t pacman_dir,
   output logic                 pause,
   output logic                 round_active,
   output logic                 level_up,
   output logic                 round_restart,
   output logic                 restart_req,
   output logic                 restart_dots,
   output logic                 lose_game
);
   import game_pkg::*;

   localparam ticks_t freeze_ticks = freeze_seconds * ticks_per_second;

   typedef enum logic [1:0] {
      seq_run,
      seq_freeze,
      seq_request,
      seq_release
   } seq_state_t;

   seq_state_t state;
   ticks_t freeze_count;
   logic level_round;

   assign round_active = (state == seq_run) && !lose_game;
   assign restart_dots = restart_req && level_round;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= seq_run;
         freeze_count <= '0;
         level_round <= 1'b0;
         pause <= 1'b0;
         lose_game <= 1'b0;
         level_up <= 1'b0;
         round_restart <= 1'b0;
         restart_req <= 1'b0;
      end else begin
         level_up <= 1'b0;
         round_restart <= 1'b0;
         if (lose_game || out_of_lives) begin
            // game over until reset
            lose_game <= 1'b1;
            pause <= 1'b1;
         end else begin
            case (state)
               seq_run: begin
                  if (life_lost || all_dots_eaten) begin
                     state <= seq_freeze;
                     freeze_count <= '0;
                     pause <= 1'b1;
                     level_up <= all_dots_eaten;
                     level_round <= all_dots_eaten;
                  end else if (ready) begin
                     pause <= 1'b0;
                  end else if (pacman_dir == idle) begin
                     pause <= 1'b1;
                  end
               end
               seq_freeze: begin
                  if (freeze_count == freeze_ticks - 1) begin
                     state <= seq_request;
                     restart_req <= 1'b1;
                  end else begin
                     freeze_count <= freeze_count + 1;
                  end
               end
               seq_request: begin
                  if (restart_ack) begin
                     state <= seq_release;
                     restart_req <= 1'b0;
                  end
               end
               default: begin
                  // movers done, resume play
                  if (!restart_ack) begin
                     state <= seq_run;
                     round_restart <= 1'b1;
                     pause <= 1'b0;
                     level_round <= 1'b0;
                  end
               end
            endcase
         end
      end
   end

endmodule

//--- logic/house_release.sv
`timescale 1ns/1ns

module house_release (
   input  logic         clk,
   input  logic         reset,
   input  logic         pause,
   input  logic         round_restart,
   mode_timing_if.house timing,
   output logic         pinky_leave,
   output logic         inky_leave,
   output logic         clyde_leave
);
   import game_pkg::*;

   ticks_t leave_count;
   ticks_t next_count;

   assign next_count = leave_count + 1'b1;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         leave_count <= '0;
         pinky_leave <= 1'b0;
         inky_leave <= 1'b0;
         clyde_leave <= 1'b0;
      end else if (round_restart) begin
         leave_count <= '0;
         pinky_leave <= 1'b0;
         inky_leave <= 1'b0;
         clyde_leave <= 1'b0;
      end else if (!pause && !clyde_leave) begin
         // clyde leaves last, counter parks there
         leave_count <= next_count;
         if (next_count >= timing.pinky_leave_ticks) begin
            pinky_leave <= 1'b1;
         end
         if (next_count >= timing.inky_leave_ticks) begin
            inky_leave <= 1'b1;
         end
         if (next_count >= timing.clyde_leave_ticks) begin
            clyde_leave <= 1'b1;
         end
      end
   end

endmodule

//--- logic/game_master_top.sv
`timescale 1ns/1ns

module game_master_top #(
   parameter game_pkg::ticks_t ticks_per_second = 25_000_000
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  ready,
   input  logic                  energizer,
   input  logic                  all_dots_eaten,
   input  logic                  restart_ack,
   input  game_pkg::direction_t  pacman_dir,
   input  game_pkg::tile_t       pacman_x,
   input  game_pkg::tile_t       pacman_y,
   input  game_pkg::tile_t       blinky_x,
   input  game_pkg::tile_t       blinky_y,
   input  game_pkg::tile_t       pinky_x,
   input  game_pkg::tile_t       pinky_y,
   input  game_pkg::tile_t       inky_x,
   input  game_pkg::tile_t       inky_y,
   input  game_pkg::tile_t       clyde_x,
   input  game_pkg::tile_t       clyde_y,
   input  game_pkg::ghost_mode_t blinky_mode,
   input  game_pkg::ghost_mode_t pinky_mode,
   input  game_pkg::ghost_mode_t inky_mode,
   input  game_pkg::ghost_mode_t clyde_mode,
   output logic                  pause,
   output logic                  lose_game,
   output logic                  restart_req,
   output logic                  restart_dots,
   output game_pkg::level_t      level,
   output game_pkg::lives_t      lives,
   output game_pkg::score_t      score,
   output game_pkg::ghost_mode_t global_mode,
   output logic                  twinkle,
   output logic                  pinky_leave,
   output logic                  inky_leave,
   output logic                  clyde_leave
);

   logic level_up;
   logic round_restart;
   logic round_active;
   logic life_lost;
   logic out_of_lives;

   mode_timing_if timing_bus ();

   level_config #(
      .ticks_per_second(ticks_per_second)
   ) u_level_config (
      .clk(clk),
      .reset(reset),
      .level_up(level_up),
      .level(level),
      .timing(timing_bus.cfg)
   );

   mode_scheduler u_mode_scheduler (
      .clk(clk),
      .reset(reset),
      .pause(pause),
      .round_restart(round_restart),
      .energizer(energizer),
      .level(level),
      .timing(timing_bus.sched),
      .global_mode(global_mode),
      .twinkle(twinkle)
   );

   collision_judge u_collision_judge (
      .clk(clk),
      .reset(reset),
      .round_active(round_active),
      .pacman_x(pacman_x),
      .pacman_y(pacman_y),
      .blinky_x(blinky_x),
      .blinky_y(blinky_y),
      .pinky_x(pinky_x),
      .pinky_y(pinky_y),
      .inky_x(inky_x),
      .inky_y(inky_y),
      .clyde_x(clyde_x),
      .clyde_y(clyde_y),
      .blinky_mode(blinky_mode),
      .pinky_mode(pinky_mode),
      .inky_mode(inky_mode),
      .clyde_mode(clyde_mode),
      .lives(lives),
      .score(score),
      .life_lost(life_lost),
      .out_of_lives(out_of_lives)
   );

   round_sequencer #(
      .ticks_per_second(ticks_per_second)
   ) u_round_sequencer (
      .clk(clk),
      .reset(reset),
      .ready(ready),
      .all_dots_eaten(all_dots_eaten),
      .life_lost(life_lost),
      .out_of_lives(out_of_lives),
      .restart_ack(restart_ack),
      .pacman_dir(pacman_dir),
      .pause(pause),
      .round_active(round_active),
      .level_up(level_up),
      .round_restart(round_restart),
      .restart_req(restart_req),
      .restart_dots(restart_dots),
      .lose_game(lose_game)
   );

   house_release u_house_release (
      .clk(clk),
      .reset(reset),
      .pause(pause),
      .round_restart(round_restart),
      .timing(timing_bus.house),
      .pinky_leave(pinky_leave),
      .inky_leave(inky_leave),
      .clyde_leave(clyde_leave)
   );

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
   parameter int period = 4,
   parameter int reset_cycles = 3
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // release just after an edge, like every other input
   initial begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #1;
      reset = 1'b0;
   end

endmodule

//--- tests/game_master_tb.sv
`timescale 1ns/1ns

module game_master_tb;
   import game_pkg::*;

   localparam int ticks_per_second = 2;
   localparam int scatter_cycles = 10 * ticks_per_second;
   localparam int chase_cycles = 15 * ticks_per_second;
   localparam int fright_cycles = 7 * ticks_per_second;
   localparam int twinkle_cycles = 2 * ticks_per_second;
   localparam int freeze_cycles = 1 * ticks_per_second;
   localparam int pinky_cycles = 15 * ticks_per_second;
   localparam int inky_cycles = 25 * ticks_per_second;
   localparam int clyde_cycles = 35 * ticks_per_second;
   localparam int points = 200;
   localparam int max_ack_delay = 4;
   // about ten times what the tests take
   localparam int watchdog_cycles = 2000;
   localparam tile_t pac_x = 5'd5;
   localparam tile_t pac_y = 5'd5;

   logic clk;
   logic reset;
   logic ready;
   logic energizer;
   logic all_dots_eaten;
   logic restart_ack;
   direction_t pacman_dir;
   tile_t pacman_x, pacman_y;
   tile_t blinky_x, blinky_y, pinky_x, pinky_y, inky_x, inky_y, clyde_x, clyde_y;
   ghost_mode_t blinky_mode, pinky_mode, inky_mode, clyde_mode;
   logic pause, lose_game, restart_req, restart_dots, twinkle;
   logic pinky_leave, inky_leave, clyde_leave;
   level_t level;
   lives_t lives;
   score_t score;
   ghost_mode_t global_mode;
   integer seed = 32'hcc4d;
   int expected_score = 0;

   clock_gen #(.period(4), .reset_cycles(3)) u_clock_gen (.clk(clk), .reset(reset));

   game_master_top #(.ticks_per_second(ticks_per_second)) UUT (
      .clk(clk), .reset(reset), .ready(ready), .energizer(energizer),
      .all_dots_eaten(all_dots_eaten), .restart_ack(restart_ack),
      .pacman_dir(pacman_dir), .pacman_x(pacman_x), .pacman_y(pacman_y),
      .blinky_x(blinky_x), .blinky_y(blinky_y), .pinky_x(pinky_x), .pinky_y(pinky_y),
      .inky_x(inky_x), .inky_y(inky_y), .clyde_x(clyde_x), .clyde_y(clyde_y),
      .blinky_mode(blinky_mode), .pinky_mode(pinky_mode),
      .inky_mode(inky_mode), .clyde_mode(clyde_mode),
      .pause(pause), .lose_game(lose_game), .restart_req(restart_req),
      .restart_dots(restart_dots), .level(level), .lives(lives), .score(score),
      .global_mode(global_mode), .twinkle(twinkle), .pinky_leave(pinky_leave),
      .inky_leave(inky_leave), .clyde_leave(clyde_leave)
   );

   task automatic report_error(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("Simulation FAILED");
      $fatal(1, "check failed");
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #1;
   endtask

   // every ghost on its own tile, away from pacman
   task automatic park_ghosts();
      blinky_x = 5'd1;
      blinky_y = 5'd1;
      pinky_x = 5'd2;
      pinky_y = 5'd2;
      inky_x = 5'd3;
      inky_y = 5'd3;
      clyde_x = 5'd4;
      clyde_y = 5'd4;
      blinky_mode = scatter;
      pinky_mode = scatter;
      inky_mode = scatter;
      clyde_mode = scatter;
   endtask

   task automatic check_reset_values();
      assert (!pause && !lose_game && !restart_req && !restart_dots && !twinkle)
         else report_error("a control output is high after reset");
      assert (!pinky_leave && !inky_leave && !clyde_leave)
         else report_error("a leave flag is high after reset");
      assert (lives == lives_t'(3) && score == '0 && level == level_t'(1))
         else report_error($sformatf("lives %0d score %0d level %0d after reset",
                                     lives, score, level));
      assert (global_mode == scatter) else report_error("mode is not scatter after reset");
   endtask

   task automatic check_frightened(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         assert (global_mode == frightened)
            else report_error($sformatf("left frightened after %0d cycles", i));
         assert (twinkle == (i >= fright_cycles - twinkle_cycles))
            else report_error($sformatf("twinkle %0b in frightened cycle %0d", twinkle, i));
         step_cycle();
      end
   endtask

   task automatic lose_life(input int lives_left);
      blinky_x = pac_x;
      blinky_y = pac_y;
      blinky_mode = chase;
      step_cycle();
      park_ghosts();
      assert (lives == lives_t'(lives_left))
         else report_error($sformatf("lives %0d, expected %0d", lives, lives_left));
      step_cycle();
      assert (pause) else report_error("pause did not rise after a lost life");
   endtask

   // freeze, four-phase handshake, then back to play
   task automatic finish_restart(input logic dots_round);
      int frozen;
      frozen = 0;
      while (!restart_req) begin
         assert (pause && !restart_dots) else report_error("bad state during freeze");
         frozen++;
         step_cycle();
      end
      assert (frozen == freeze_cycles)
         else report_error($sformatf("froze %0d cycles, expected %0d", frozen, freeze_cycles));
      while (restart_req) begin
         assert (pause && restart_dots == dots_round)
            else report_error($sformatf("restart_dots %0b, expected %0b",
                                        restart_dots, dots_round));
         step_cycle();
      end
      while (pause) begin
         assert (!restart_dots) else report_error("restart_dots high after request");
         step_cycle();
      end
      step_cycle();
      assert (global_mode == scatter) else report_error("mode is not scatter after restart");
      assert (!pinky_leave && !twinkle) else report_error("flags not cleared by restart");
   endtask

   // movers side of the handshake
   initial begin : ack_responder
      int delay;
      restart_ack = 1'b0;
      forever begin
         step_cycle();
         if (restart_req) begin
            delay = $unsigned($random(seed)) % max_ack_delay;
            repeat (delay) step_cycle();
            restart_ack = 1'b1;
            while (restart_req) step_cycle();
            delay = $unsigned($random(seed)) % max_ack_delay;
            repeat (delay) step_cycle();
            restart_ack = 1'b0;
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset) restart_dots |-> restart_req)
      else report_error("restart_dots high without restart_req");
   assert property (@(posedge clk) disable iff (reset) $fell(restart_req) |-> $past(restart_ack))
      else report_error("restart_req dropped before restart_ack");
   assert property (@(posedge clk) disable iff (reset)
                    $fell(pause) && !lose_game |-> !$past(restart_ack))
      else report_error("round resumed while restart_ack was high");
   assert property (@(posedge clk) disable iff (reset) lose_game |-> pause)
      else report_error("pause low after game over");

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
      $display("Simulation FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      ready = 1'b0;
      energizer = 1'b0;
      all_dots_eaten = 1'b0;
      pacman_dir = right;
      pacman_x = pac_x;
      pacman_y = pac_y;
      park_ghosts();
      @(negedge reset);
      check_reset_values();

      // scatter, chase, scatter, with the house releases on the way
      for (int i = 0; i < scatter_cycles + chase_cycles; i++) begin
         assert (global_mode == ((i < scatter_cycles) ? scatter : chase))
            else report_error($sformatf("mode %s in cycle %0d", global_mode.name(), i));
         assert (pinky_leave == (i >= pinky_cycles))
            else report_error($sformatf("pinky_leave %0b in cycle %0d", pinky_leave, i));
         assert (!inky_leave && !clyde_leave)
            else report_error($sformatf("inky or clyde left early in cycle %0d", i));
         step_cycle();
      end
      assert (global_mode == scatter) else report_error("no scatter after first chase");
      assert (inky_leave && !clyde_leave)
         else report_error($sformatf("inky_leave %0b clyde_leave %0b after %0d cycles",
                                     inky_leave, clyde_leave, inky_cycles));

      while (global_mode != chase) step_cycle();
      assert (clyde_leave)
         else report_error($sformatf("clyde_leave low after %0d cycles", clyde_cycles));
      energizer = 1'b1;
      step_cycle();
      energizer = 1'b0;
      check_frightened(fright_cycles);
      assert (global_mode == chase) else report_error("did not return to chase");
      energizer = 1'b1;
      step_cycle();
      energizer = 1'b0;
      check_frightened(5);
      // second energizer restarts the count
      energizer = 1'b1;
      step_cycle();
      energizer = 1'b0;
      check_frightened(fright_cycles);
      assert (global_mode == chase) else report_error("did not return to chase");

      lose_life(2);
      finish_restart(1'b0);

      pinky_x = pac_x;
      pinky_y = pac_y;
      inky_x = pac_x;
      inky_y = pac_y;
      pinky_mode = frightened;
      inky_mode = frightened;
      step_cycle();
      park_ghosts();
      expected_score = expected_score + 2 * points;
      step_cycle();
      assert (score == score_t'(expected_score) && lives == lives_t'(2))
         else report_error($sformatf("score %0d lives %0d, expected %0d and 2",
                                     score, lives, expected_score));

      all_dots_eaten = 1'b1;
      step_cycle();
      all_dots_eaten = 1'b0;
      finish_restart(1'b1);
      assert (level == level_t'(2)) else report_error($sformatf("level %0d, expected 2", level));

      lose_life(1);
      finish_restart(1'b0);
      lose_life(0);
      repeat (10) begin
         assert (lose_game && pause && !restart_req)
            else report_error("game over did not hold");
         step_cycle();
      end

      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- project.f
logic/game_pkg.sv
logic/mode_timing_if.sv
logic/level_config.sv
logic/mode_scheduler.sv
logic/collision_judge.sv
logic/round_sequencer.sv
logic/house_release.sv
logic/game_master_top.sv
tests/clock_gen.sv
tests/game_master_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := game_master_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
